// File: list.f
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/id_ex_if.sv
rtl/register_file.sv
rtl/main_control.sv
rtl/instruction_decode.sv
rtl/alu_execute.sv
rtl/decode_top.sv
testbench/tb_decode_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_decode_top -f list.f -o tb_decode_top
./obj_dir/tb_decode_top | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi

// File: testbench/tb_decode_top.sv
`default_nettype none

module tb_decode_top;

  logic                        i_clk;
  logic                        i_rst;
  logic [isa_pkg::XLEN-1:0]    i_instruction;
  logic [isa_pkg::XLEN-1:0]    i_pc_plus4;
  logic                        i_wb_en;
  logic [isa_pkg::REG_AW-1:0]  i_wb_addr;
  logic [isa_pkg::XLEN-1:0]    i_wb_data;
  wire  [isa_pkg::REG_AW-1:0]  o_rs, o_rt, o_rd, o_write_reg;
  wire  [isa_pkg::XLEN-1:0]    o_imm_ext, o_data1, o_data2, o_alu_result, o_branch_target;
  wire  [ctrl_pkg::ALUC_W-1:0] o_alu_ctrl;
  wire                         o_reg_dst, o_jump, o_branch, o_mem_read, o_mem_to_reg;
  wire                         o_mem_write, o_alu_src, o_reg_write, o_branch_taken;
  wire                         o_ex_reg_write;

  // Register contents as the testbench expects them
  logic [isa_pkg::XLEN-1:0]    shadow [isa_pkg::REG_COUNT];
  logic [15:0]                 lfsr;

  decode_top UUT (.*);

  initial
  begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  // Expected {control bits, ALU code} for one instruction
  function automatic logic [11:0] ref_decode(input logic [31:0] ins);
    ctrl_pkg::ctrl_t             c;
    logic [ctrl_pkg::ALUC_W-1:0] aluc;
    c    = '0;
    aluc = ctrl_pkg::ALUC_ADD;
    case (ins[31:26])
      isa_pkg::OP_RTYPE: c = 8'b1000_0001;
      isa_pkg::OP_LW:    c = 8'b1101_1000;
      isa_pkg::OP_SW:    c = 8'b0110_0000;
      isa_pkg::OP_ADDI:  c = 8'b1100_0000;
      isa_pkg::OP_J:     c = 8'b0000_0010;
      isa_pkg::OP_BEQ:
      begin
        c    = 8'b0000_0100;
        aluc = ctrl_pkg::ALUC_SUB;
      end
      default:           c = '0;
    endcase
    if (ins[31:26] == isa_pkg::OP_RTYPE)
    begin
      case (ins[5:0])
        isa_pkg::F_ADD: aluc = ctrl_pkg::ALUC_ADD;
        isa_pkg::F_SUB: aluc = ctrl_pkg::ALUC_SUB;
        isa_pkg::F_AND: aluc = ctrl_pkg::ALUC_AND;
        isa_pkg::F_OR:  aluc = ctrl_pkg::ALUC_OR;
        isa_pkg::F_SLT: aluc = ctrl_pkg::ALUC_SLT;
        isa_pkg::F_NOR: aluc = ctrl_pkg::ALUC_NOR;
        isa_pkg::F_SLL: aluc = ctrl_pkg::ALUC_SLL;
        isa_pkg::F_SRL: aluc = ctrl_pkg::ALUC_SRL;
        default:        c.reg_write = 1'b0;
      endcase
    end
    return {c, aluc};
  endfunction

  // Expected ALU result, a = rs data, b = rt data
  function automatic logic [31:0] ref_result(input logic [31:0] ins, input logic [31:0] a,
                                              input logic [31:0] b);
    if (ins[31:26] == isa_pkg::OP_BEQ)
      return a - b;
    if (ins[31:26] != isa_pkg::OP_RTYPE)
      return a + {{16{ins[15]}}, ins[15:0]};
    case (ins[5:0])
      isa_pkg::F_SUB: return a - b;
      isa_pkg::F_AND: return a & b;
      isa_pkg::F_OR:  return a | b;
      isa_pkg::F_NOR: return ~(a | b);
      isa_pkg::F_SLT: return 32'($signed(a) < $signed(b));
      isa_pkg::F_SLL: return b << ins[10:6];
      isa_pkg::F_SRL: return b >> ins[10:6];
      default:        return a + b;
    endcase
  endfunction

  task automatic fail_stop();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic writeback(input logic [4:0] addr, input logic [31:0] data);
    @(posedge i_clk);
    i_wb_en   <= 1'b1;
    i_wb_addr <= addr;
    i_wb_data <= data;
    if (addr != 5'd0)
      shadow[addr] = data;
  endtask

  // Issue one instruction, check decode after one edge and execute after two
  task automatic exec_instr(input string name, input logic [31:0] ins,
                            input logic [31:0] pc, input logic wb_en = 1'b0,
                            input logic [4:0] wb_addr = 5'd0,
                            input logic [31:0] wb_data = 32'd0);
    logic [11:0]     dec;
    ctrl_pkg::ctrl_t c;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     imm;
    @(posedge i_clk);
    i_instruction <= ins;
    i_pc_plus4    <= pc;
    i_wb_en       <= wb_en;
    i_wb_addr     <= wb_addr;
    i_wb_data     <= wb_data;
    if (wb_en && wb_addr != 5'd0)
      shadow[wb_addr] = wb_data;
    dec = ref_decode(ins);
    c   = dec[11:4];
    a   = shadow[ins[25:21]];
    b   = shadow[ins[20:16]];
    imm = {{16{ins[15]}}, ins[15:0]};
    @(posedge i_clk);
    @(negedge i_clk);
    check({name, " rs"}, 32'(ins[25:21]), 32'(o_rs));
    check({name, " rt"}, 32'(ins[20:16]), 32'(o_rt));
    check({name, " rd"}, 32'(ins[15:11]), 32'(o_rd));
    check({name, " imm_ext"}, imm, o_imm_ext);
    check({name, " data1"}, a, o_data1);
    check({name, " data2"}, b, o_data2);
    check({name, " ctrl"}, 32'(c), 32'({o_reg_write, o_alu_src, o_mem_write, o_mem_to_reg,
                                          o_mem_read, o_branch, o_jump, o_reg_dst}));
    check({name, " alu_ctrl"}, 32'(dec[3:0]), 32'(o_alu_ctrl));
    @(posedge i_clk);
    @(negedge i_clk);
    if (ins[31:26] != isa_pkg::OP_J)
      check({name, " alu_result"}, ref_result(ins, a, b), o_alu_result);
    check({name, " write_reg"}, 32'(c.reg_dst ? ins[15:11] : ins[20:16]), 32'(o_write_reg));
    check({name, " branch_taken"}, 32'(c.branch && (a == b)), 32'(o_branch_taken));
    check({name, " branch_target"}, pc + (imm << 2), o_branch_target);
    check({name, " ex_reg_write"}, 32'(c.reg_write), 32'(o_ex_reg_write));
  endtask

  task automatic run_rtype(input string name, input logic [5:0] fn);
    logic [4:0] sh;
    sh = 5'(rand_bits(5));
    // Shift amount only matters for sll and srl
    if (fn != isa_pkg::F_SLL && fn != isa_pkg::F_SRL)
      sh = 5'd0;
    exec_instr(name, {isa_pkg::OP_RTYPE, 5'(rand_bits(5)), 5'(rand_bits(5)),
                      5'(rand_bits(5)), sh, fn}, 32'(rand_bits(30)) << 2);
  endtask

  task automatic run_itype(input string name, input logic [5:0] op);
    exec_instr(name, {op, 5'(rand_bits(5)), 5'(rand_bits(5)), 16'(rand_bits(16))},
               32'(rand_bits(30)) << 2);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////
  initial
  begin
    logic [31:0] v;
    i_rst         = 1'b0;
    // Taken beq and then lw held in the pipe while reset is asserted
    i_instruction = {isa_pkg::OP_BEQ, 5'd0, 5'd0, 16'd0};
    i_pc_plus4    = '0;
    i_wb_en       = 1'b0;
    i_wb_addr     = '0;
    i_wb_data     = '0;
    lfsr          = 16'd17051;
    for (int r = 0; r < 32; r++)
      shadow[r] = '0;
    repeat (4) @(posedge i_clk);
    i_instruction <= {isa_pkg::OP_LW, 5'd0, 5'd0, 16'd0};
    @(posedge i_clk);
    i_rst <= 1'b1;

    // Reset state, execute side looked at again one edge later
    @(negedge i_clk);
    check("reset ctrl", 32'd0, 32'({o_reg_dst, o_jump, o_branch, o_mem_read, o_mem_to_reg,
                                     o_mem_write, o_alu_src, o_reg_write}));
    check("reset branch_taken", 32'd0, 32'(o_branch_taken));
    @(negedge i_clk);
    check("reset ex_reg_write", 32'd0, 32'(o_ex_reg_write));
    for (int r = 0; r < 32; r++)
      exec_instr("reset read", {isa_pkg::OP_RTYPE, 5'(r), 5'(31 - r), 5'd1, 5'd0,
                                isa_pkg::F_ADD}, 32'h0000_0004);

    // R-type arithmetic on random register contents
    for (int r = 1; r < 32; r++)
      writeback(5'(r), rand_bits(32));
    for (int k = 0; k < 4; k++)
    begin
      run_rtype("add", isa_pkg::F_ADD);
      run_rtype("sub", isa_pkg::F_SUB);
      run_rtype("and", isa_pkg::F_AND);
      run_rtype("or", isa_pkg::F_OR);
      run_rtype("nor", isa_pkg::F_NOR);
      run_rtype("slt", isa_pkg::F_SLT);
    end

    // Immediates
    for (int k = 0; k < 4; k++)
    begin
      run_itype("addi", isa_pkg::OP_ADDI);
      run_itype("lw", isa_pkg::OP_LW);
      run_itype("sw", isa_pkg::OP_SW);
    end
    exec_instr("addi neg", {isa_pkg::OP_ADDI, 5'd3, 5'd4, 16'hFFF8}, 32'h0000_0100);
    exec_instr("lw neg", {isa_pkg::OP_LW, 5'd5, 5'd6, 16'h8000}, 32'h0000_0200);

    // Branch and jump
    v = rand_bits(32);
    writeback(5'd7, v);
    writeback(5'd8, v);
    writeback(5'd9, v ^ 32'h1);
    exec_instr("beq taken", {isa_pkg::OP_BEQ, 5'd7, 5'd8, 16'hFFFC}, 32'h0000_1000);
    exec_instr("beq self", {isa_pkg::OP_BEQ, 5'd9, 5'd9, 16'(rand_bits(16))}, 32'h0000_2000);
    exec_instr("beq not taken", {isa_pkg::OP_BEQ, 5'd7, 5'd9, 16'(rand_bits(16))},
               32'h0000_3000);
    exec_instr("j", {isa_pkg::OP_J, 26'(rand_bits(26))}, 32'h0000_4000);

    // Register-file edges
    writeback(5'd0, 32'hDEAD_BEEF);
    exec_instr("r0 write", {isa_pkg::OP_RTYPE, 5'd0, 5'd0, 5'd2, 5'd0, isa_pkg::F_OR},
               32'h0000_0008);
    exec_instr("write-first", {isa_pkg::OP_RTYPE, 5'd10, 5'd10, 5'd11, 5'd0, isa_pkg::F_OR},
               32'h0000_000C, 1'b1, 5'd10, 32'h1234_5678);
    exec_instr("write-first r0", {isa_pkg::OP_RTYPE, 5'd0, 5'd0, 5'd11, 5'd0, isa_pkg::F_OR},
               32'h0000_0010, 1'b1, 5'd0, 32'h0BAD_F00D);

    // Shifts
    for (int k = 0; k < 4; k++)
    begin
      run_rtype("sll", isa_pkg::F_SLL);
      run_rtype("srl", isa_pkg::F_SRL);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/decode_top.sv
`default_nettype none

module decode_top
(
  input  wire                         i_clk,
  input  wire                         i_rst,
  input  wire  [isa_pkg::XLEN-1:0]    i_instruction,
  input  wire  [isa_pkg::XLEN-1:0]    i_pc_plus4,
  input  wire                         i_wb_en,
  input  wire  [isa_pkg::REG_AW-1:0]  i_wb_addr,
  input  wire  [isa_pkg::XLEN-1:0]    i_wb_data,
  output logic [isa_pkg::REG_AW-1:0]  o_rs,
  output logic [isa_pkg::REG_AW-1:0]  o_rt,
  output logic [isa_pkg::REG_AW-1:0]  o_rd,
  output logic [isa_pkg::XLEN-1:0]    o_imm_ext,
  output logic [isa_pkg::XLEN-1:0]    o_data1,
  output logic [isa_pkg::XLEN-1:0]    o_data2,
  output logic                        o_reg_dst,
  output logic                        o_jump,
  output logic                        o_branch,
  output logic                        o_mem_read,
  output logic                        o_mem_to_reg,
  output logic                        o_mem_write,
  output logic                        o_alu_src,
  output logic                        o_reg_write,
  output logic [ctrl_pkg::ALUC_W-1:0] o_alu_ctrl,
  output logic [isa_pkg::XLEN-1:0]    o_alu_result,
  output logic [isa_pkg::REG_AW-1:0]  o_write_reg,
  output logic                        o_branch_taken,
  output logic [isa_pkg::XLEN-1:0]    o_branch_target,
  output logic                        o_ex_reg_write
);

  id_ex_if u_id_ex ();

  instruction_decode u_instruction_decode
  (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_instruction (i_instruction),
    .i_pc_plus4    (i_pc_plus4),
    .i_wb_en       (i_wb_en),
    .i_wb_addr     (i_wb_addr),
    .i_wb_data     (i_wb_data),
    .id_ex         (u_id_ex.producer)
  );

  alu_execute u_alu_execute
  (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .id_ex           (u_id_ex.consumer),
    .o_alu_result    (o_alu_result),
    .o_write_reg     (o_write_reg),
    .o_branch_taken  (o_branch_taken),
    .o_branch_target (o_branch_target),
    .o_reg_write     (o_ex_reg_write)
  );

  // Decode stage view, straight off the pipeline register
  assign o_rs         = u_id_ex.rs;
  assign o_rt         = u_id_ex.rt;
  assign o_rd         = u_id_ex.rd;
  assign o_imm_ext    = u_id_ex.imm_ext;
  assign o_data1      = u_id_ex.data1;
  assign o_data2      = u_id_ex.data2;
  assign o_reg_dst    = u_id_ex.ctrl.reg_dst;
  assign o_jump       = u_id_ex.ctrl.jump;
  assign o_branch     = u_id_ex.ctrl.branch;
  assign o_mem_read   = u_id_ex.ctrl.mem_read;
  assign o_mem_to_reg = u_id_ex.ctrl.mem_to_reg;
  assign o_mem_write  = u_id_ex.ctrl.mem_write;
  assign o_alu_src    = u_id_ex.ctrl.alu_src;
  assign o_reg_write  = u_id_ex.ctrl.reg_write;
  assign o_alu_ctrl   = u_id_ex.alu_ctrl;

endmodule

`default_nettype wire

// File: rtl/alu_execute.sv
`default_nettype none

module alu_execute
(
  input  wire                         i_clk,
  input  wire                         i_rst,
  id_ex_if.consumer                   id_ex,
  output logic [isa_pkg::XLEN-1:0]    o_alu_result,
  output logic [isa_pkg::REG_AW-1:0]  o_write_reg,
  output logic                        o_branch_taken,
  output logic [isa_pkg::XLEN-1:0]    o_branch_target,
  output logic                        o_reg_write
);

  logic [isa_pkg::XLEN-1:0]   operand_b;
  logic [isa_pkg::XLEN-1:0]   alu_result;
  logic [isa_pkg::REG_AW-1:0] write_reg;
  logic                       branch_taken;
  logic [isa_pkg::XLEN-1:0]   branch_target;

  // Immediate replaces rt data for lw, sw, addi
  assign operand_b = id_ex.ctrl.alu_src ? id_ex.imm_ext : id_ex.data2;

  ////////////////////
  // ALU
  ////////////////////
  always_comb
  begin
    case (id_ex.alu_ctrl)
      ctrl_pkg::ALUC_AND: alu_result = id_ex.data1 & operand_b;
      ctrl_pkg::ALUC_OR:  alu_result = id_ex.data1 | operand_b;
      ctrl_pkg::ALUC_ADD: alu_result = id_ex.data1 + operand_b;
      ctrl_pkg::ALUC_SUB: alu_result = id_ex.data1 - operand_b;
      ctrl_pkg::ALUC_SLT:
      begin
        alu_result = {{(isa_pkg::XLEN-1){1'b0}},
                      ($signed(id_ex.data1) < $signed(operand_b))};
      end
      ctrl_pkg::ALUC_NOR: alu_result = ~(id_ex.data1 | operand_b);
      // Shifts act on rt by shamt
      ctrl_pkg::ALUC_SLL: alu_result = id_ex.data2 << id_ex.shamt;
      ctrl_pkg::ALUC_SRL: alu_result = id_ex.data2 >> id_ex.shamt;
      default:            alu_result = '0;
    endcase
  end

  assign write_reg     = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;
  assign branch_taken  = id_ex.ctrl.branch && (id_ex.data1 == id_ex.data2);
  assign branch_target = id_ex.pc_plus4 + {id_ex.imm_ext[isa_pkg::XLEN-3:0], 2'b00};

  always_ff @(posedge i_clk)
  begin
    if (!i_rst)
    begin
      o_alu_result    <= '0;
      o_write_reg     <= '0;
      o_branch_taken  <= 1'b0;
      o_branch_target <= '0;
      o_reg_write     <= 1'b0;
    end
    else
    begin
      o_alu_result    <= alu_result;
      o_write_reg     <= write_reg;
      o_branch_taken  <= branch_taken;
      o_branch_target <= branch_target;
      o_reg_write     <= id_ex.ctrl.reg_write;
    end
  end

endmodule

`default_nettype wire

// File: rtl/instruction_decode.sv
`default_nettype none

module instruction_decode
(
  input  wire                        i_clk,
  input  wire                        i_rst,
  input  wire [isa_pkg::XLEN-1:0]    i_instruction,
  input  wire [isa_pkg::XLEN-1:0]    i_pc_plus4,
  input  wire                        i_wb_en,
  input  wire [isa_pkg::REG_AW-1:0]  i_wb_addr,
  input  wire [isa_pkg::XLEN-1:0]    i_wb_data,
  id_ex_if.producer                  id_ex
);

  logic [isa_pkg::OPCODE_W-1:0] opcode;
  logic [isa_pkg::REG_AW-1:0]   rs;
  logic [isa_pkg::REG_AW-1:0]   rt;
  logic [isa_pkg::REG_AW-1:0]   rd;
  logic [isa_pkg::SHAMT_W-1:0]  shamt;
  logic [isa_pkg::FUNCT_W-1:0]  funct;
  logic [isa_pkg::IMM_W-1:0]    imm;
  logic [isa_pkg::XLEN-1:0]     imm_ext;
  logic [isa_pkg::XLEN-1:0]     data1;
  logic [isa_pkg::XLEN-1:0]     data2;
  ctrl_pkg::ctrl_t              ctrl;
  logic [ctrl_pkg::ALUC_W-1:0]  alu_ctrl;

  ////////////////////
  // Field split
  ////////////////////
  assign opcode  = i_instruction[31:26];
  assign rs      = i_instruction[25:21];
  assign rt      = i_instruction[20:16];
  assign rd      = i_instruction[15:11];
  assign shamt   = i_instruction[10:6];
  assign funct   = i_instruction[5:0];
  assign imm     = i_instruction[15:0];
  assign imm_ext = {{(isa_pkg::XLEN - isa_pkg::IMM_W){imm[isa_pkg::IMM_W-1]}}, imm};

  register_file u_register_file
  (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rd_addr1 (rs),
    .i_rd_addr2 (rt),
    .i_wb_en    (i_wb_en),
    .i_wb_addr  (i_wb_addr),
    .i_wb_data  (i_wb_data),
    .o_rd_data1 (data1),
    .o_rd_data2 (data2)
  );

  main_control u_main_control
  (
    .i_opcode   (opcode),
    .i_funct    (funct),
    .o_ctrl     (ctrl),
    .o_alu_ctrl (alu_ctrl)
  );

  // Decode/execute pipeline register
  always_ff @(posedge i_clk)
  begin
    if (!i_rst)
    begin
      id_ex.pc_plus4 <= '0;
      id_ex.rs       <= '0;
      id_ex.rt       <= '0;
      id_ex.rd       <= '0;
      id_ex.shamt    <= '0;
      id_ex.imm_ext  <= '0;
      id_ex.data1    <= '0;
      id_ex.data2    <= '0;
      id_ex.ctrl     <= '0;
      id_ex.alu_ctrl <= '0;
    end
    else
    begin
      id_ex.pc_plus4 <= i_pc_plus4;
      id_ex.rs       <= rs;
      id_ex.rt       <= rt;
      id_ex.rd       <= rd;
      id_ex.shamt    <= shamt;
      id_ex.imm_ext  <= imm_ext;
      id_ex.data1    <= data1;
      id_ex.data2    <= data2;
      id_ex.ctrl     <= ctrl;
      id_ex.alu_ctrl <= alu_ctrl;
    end
  end

endmodule

`default_nettype wire

// File: rtl/main_control.sv
`default_nettype none

module main_control
(
  input  wire  [isa_pkg::OPCODE_W-1:0] i_opcode,
  input  wire  [isa_pkg::FUNCT_W-1:0]  i_funct,
  output ctrl_pkg::ctrl_t              o_ctrl,
  output logic [ctrl_pkg::ALUC_W-1:0]  o_alu_ctrl
);

  always_comb
  begin
    // Unknown opcodes leave everything inactive
    o_ctrl     = '0;
    o_alu_ctrl = ctrl_pkg::ALUC_ADD;

    case (i_opcode)
      isa_pkg::OP_RTYPE:
      begin
        o_ctrl.reg_dst   = 1'b1;
        o_ctrl.reg_write = 1'b1;
        case (i_funct)
          isa_pkg::F_ADD: o_alu_ctrl = ctrl_pkg::ALUC_ADD;
          isa_pkg::F_SUB: o_alu_ctrl = ctrl_pkg::ALUC_SUB;
          isa_pkg::F_AND: o_alu_ctrl = ctrl_pkg::ALUC_AND;
          isa_pkg::F_OR:  o_alu_ctrl = ctrl_pkg::ALUC_OR;
          isa_pkg::F_SLT: o_alu_ctrl = ctrl_pkg::ALUC_SLT;
          isa_pkg::F_NOR: o_alu_ctrl = ctrl_pkg::ALUC_NOR;
          isa_pkg::F_SLL: o_alu_ctrl = ctrl_pkg::ALUC_SLL;
          isa_pkg::F_SRL: o_alu_ctrl = ctrl_pkg::ALUC_SRL;
          default:
          begin
            // Unsupported funct must not write back
            o_ctrl.reg_write = 1'b0;
          end
        endcase
      end
      isa_pkg::OP_LW:
      begin
        o_ctrl.alu_src    = 1'b1;
        o_ctrl.mem_to_reg = 1'b1;
        o_ctrl.reg_write  = 1'b1;
        o_ctrl.mem_read   = 1'b1;
      end
      isa_pkg::OP_SW:
      begin
        o_ctrl.alu_src   = 1'b1;
        o_ctrl.mem_write = 1'b1;
      end
      isa_pkg::OP_BEQ:
      begin
        o_ctrl.branch = 1'b1;
        o_alu_ctrl    = ctrl_pkg::ALUC_SUB;
      end
      isa_pkg::OP_ADDI:
      begin
        o_ctrl.alu_src   = 1'b1;
        o_ctrl.reg_write = 1'b1;
      end
      isa_pkg::OP_J:
      begin
        o_ctrl.jump = 1'b1;
      end
      default:
      begin
        o_ctrl = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
`default_nettype none

module register_file
(
  input  wire                         i_clk,
  input  wire                         i_rst,
  input  wire  [isa_pkg::REG_AW-1:0]  i_rd_addr1,
  input  wire  [isa_pkg::REG_AW-1:0]  i_rd_addr2,
  input  wire                         i_wb_en,
  input  wire  [isa_pkg::REG_AW-1:0]  i_wb_addr,
  input  wire  [isa_pkg::XLEN-1:0]    i_wb_data,
  output logic [isa_pkg::XLEN-1:0]    o_rd_data1,
  output logic [isa_pkg::XLEN-1:0]    o_rd_data2
);

  logic [isa_pkg::XLEN-1:0] regs [isa_pkg::REG_COUNT];
  logic                     wb_valid;

  // Register 0 is never written
  assign wb_valid = i_wb_en && (i_wb_addr != '0);

  always_ff @(posedge i_clk)
  begin
    if (!i_rst)
    begin
      for (int i = 0; i < isa_pkg::REG_COUNT; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wb_valid)
    begin
      regs[i_wb_addr] <= i_wb_data;
    end
  end

  // Write-first read, zero register forced
  function automatic logic [isa_pkg::XLEN-1:0] read_port(input logic [isa_pkg::REG_AW-1:0] addr);
    if (addr == '0)
      return '0;
    else if (wb_valid && (addr == i_wb_addr))
      return i_wb_data;
    else
      return regs[addr];
  endfunction

  assign o_rd_data1 = read_port(i_rd_addr1);
  assign o_rd_data2 = read_port(i_rd_addr2);

endmodule

`default_nettype wire

// File: rtl/id_ex_if.sv
`default_nettype none

// Registered decode bundle, one instruction per cycle
interface id_ex_if;

  logic [isa_pkg::XLEN-1:0]     pc_plus4;
  logic [isa_pkg::REG_AW-1:0]   rs;
  logic [isa_pkg::REG_AW-1:0]   rt;
  logic [isa_pkg::REG_AW-1:0]   rd;
  logic [isa_pkg::SHAMT_W-1:0]  shamt;
  logic [isa_pkg::XLEN-1:0]     imm_ext;
  logic [isa_pkg::XLEN-1:0]     data1;
  logic [isa_pkg::XLEN-1:0]     data2;
  ctrl_pkg::ctrl_t              ctrl;
  logic [ctrl_pkg::ALUC_W-1:0]  alu_ctrl;

  modport producer (
    output pc_plus4, rs, rt, rd, shamt, imm_ext, data1, data2, ctrl, alu_ctrl
  );

  modport consumer (
    input pc_plus4, rs, rt, rd, shamt, imm_ext, data1, data2, ctrl, alu_ctrl
  );

endinterface

`default_nettype wire

// File: rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  // Main control bits, reg_write in the top bit
  typedef struct packed {
    logic reg_write;
    logic alu_src;
    logic mem_write;
    logic mem_to_reg;
    logic mem_read;
    logic branch;
    logic jump;
    logic reg_dst;
  } ctrl_t;

  ////////////////////
  // ALU control codes
  ////////////////////
  localparam int ALUC_W = 4;

  localparam logic [ALUC_W-1:0] ALUC_AND = 4'd0;
  localparam logic [ALUC_W-1:0] ALUC_OR  = 4'd1;
  localparam logic [ALUC_W-1:0] ALUC_ADD = 4'd2;
  localparam logic [ALUC_W-1:0] ALUC_SUB = 4'd6;
  localparam logic [ALUC_W-1:0] ALUC_SLT = 4'd7;
  localparam logic [ALUC_W-1:0] ALUC_NOR = 4'd12;
  localparam logic [ALUC_W-1:0] ALUC_SLL = 4'd3;
  localparam logic [ALUC_W-1:0] ALUC_SRL = 4'd4;

endpackage

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int XLEN      = 32;
  localparam int REG_COUNT = 32;
  localparam int REG_AW    = 5;
  localparam int IMM_W     = 16;
  localparam int OPCODE_W  = 6;
  localparam int FUNCT_W   = 6;
  localparam int SHAMT_W   = 5;

  ////////////////////
  // Opcodes
  ////////////////////
  localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'd0;
  localparam logic [OPCODE_W-1:0] OP_LW    = 6'd35;
  localparam logic [OPCODE_W-1:0] OP_SW    = 6'd43;
  localparam logic [OPCODE_W-1:0] OP_BEQ   = 6'd4;
  localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'd8;
  localparam logic [OPCODE_W-1:0] OP_J     = 6'd2;

  // R-type funct field
  localparam logic [FUNCT_W-1:0] F_ADD = 6'd32;
  localparam logic [FUNCT_W-1:0] F_SUB = 6'd34;
  localparam logic [FUNCT_W-1:0] F_AND = 6'd36;
  localparam logic [FUNCT_W-1:0] F_OR  = 6'd37;
  localparam logic [FUNCT_W-1:0] F_SLT = 6'd42;
  localparam logic [FUNCT_W-1:0] F_NOR = 6'd39;
  localparam logic [FUNCT_W-1:0] F_SLL = 6'd0;
  localparam logic [FUNCT_W-1:0] F_SRL = 6'd2;

endpackage

`default_nettype wire
